//--- rtl/rx_beat_if.sv
`timescale 1ns/1ps

// one AXIS beat from the PCIe core, ready travels separately
interface rx_beat_if;
	import tunnel_pkg::*;

	logic [data_w-1:0] data;
	logic [keep_w-1:0] keep;
	logic              last;
	logic              valid;

	modport source (
		output data, keep, last, valid
	);

	modport sink (
		input data, keep, last, valid
	);

endinterface

//--- rtl/tlp_hdr_rewrite.sv
`timescale 1ns/1ps

module tlp_hdr_rewrite (
	input  logic                     clk,
	input  logic                     sys_rst,
	rx_beat_if.sink                  rx,
	input  logic                     emit,
	input  tunnel_pkg::beat_kind_e   beat_kind,
	input  logic                     hdr_is_cpl,
	input  logic                     hdr_is_mem,
	input  logic                     hdr_addr64,
	input  logic [47:12]             paddr,
	output tunnel_pkg::tunnel_word_t wr_word,
	output logic                     wr_en
);
	import tlp_pkg::*;
	import tunnel_pkg::*;

	tlp_hdr0_u         hdr0;
	logic [data_w-1:0] hdr1;
	logic [data_w-1:0] next_data;
	tunnel_sb_t        sb;

	// requests get the top requester id nibble flipped
	always_comb begin
		hdr0 = rx.data;
		if (!hdr_is_cpl)
			hdr0.req.req_id[15:12] = ~hdr0.req.req_id[15:12];
	end

	// address into the host window, or the completion's requester id
	always_comb begin
		hdr1 = rx.data;
		if (hdr_is_mem && !hdr_addr64)
			hdr1[31:20] = paddr[31:20];
		else if (hdr_is_mem)
			hdr1 = {paddr[31:20], rx.data[19:0], 16'h0000, paddr[47:32]};
		else if (hdr_is_cpl)
			hdr1[31:28] = ~rx.data[31:28];
	end

	always_comb begin
		case (beat_kind)
			beat_hdr0: next_data = hdr0;
			beat_hdr1: next_data = hdr1;
			default:   next_data = rx.data;
		endcase
	end

	assign sb.tag   = sb_tag;
	assign sb.keep4 = rx.keep[4];
	assign sb.keep0 = rx.keep[0];
	assign sb.last  = rx.last;
	assign sb.valid = rx.valid;

	always_ff @(posedge clk) begin
		if (sys_rst)
			wr_en <= 1'b0;
		else
			wr_en <= emit;
	end

	always_ff @(posedge clk) begin
		if (emit)
			wr_word <= {sb, next_data};
	end

endmodule

//--- rtl/tlp_pkg.sv
package tlp_pkg;

	// header field types
	typedef logic [1:0]  tlp_fmt_t;
	typedef logic [4:0]  tlp_type_t;
	typedef logic [15:0] tlp_id_t;

	// completion with data
	localparam tlp_type_t tlp_type_cpl_d = 5'b01010;

	// type[4:1] of MRd / MWr, fmt tells 3dw or 4dw
	localparam logic [3:0] tlp_type_mem_prefix = 4'b0000;

	// first beat of a request
	// dw1 in the upper half, dw0 in the lower half
	typedef struct packed {
		tlp_id_t    req_id;
		logic [7:0] tag;
		logic [3:0] last_be;
		logic [3:0] first_be;
		logic       rsvd0;
		tlp_fmt_t   fmt;
		tlp_type_t  typ;
		logic [13:0] attr_misc;
		logic [9:0] length;
	} req_hdr0_t;

	// first beat of a completion
	typedef struct packed {
		tlp_id_t     cpl_id;
		logic [2:0]  status;
		logic        bcm;
		logic [11:0] byte_count;
		logic        rsvd0;
		tlp_fmt_t    fmt;
		tlp_type_t   typ;
		logic [13:0] attr_misc;
		logic [9:0]  length;
	} cpl_hdr0_t;

	// fmt and type sit at the same bits in both views
	typedef union packed {
		req_hdr0_t req;
		cpl_hdr0_t cpl;
	} tlp_hdr0_u;

endpackage

//--- rtl/tlp_snoop_ctrl.sv
`timescale 1ns/1ps

module tlp_snoop_ctrl (
	input  logic                   clk,
	input  logic                   sys_rst,
	rx_beat_if.sink                rx,
	input  logic                   bar_hit,
	input  logic                   en_bar,
	input  logic                   en_cpl,
	input  logic                   almost_full,
	output logic                   ready,
	output logic                   emit,
	output tunnel_pkg::beat_kind_e beat_kind,
	output logic                   hdr_is_cpl,
	output logic                   hdr_is_mem,
	output logic                   hdr_addr64,
	output logic                   tlp_start
);
	import tlp_pkg::*;
	import tunnel_pkg::*;

	typedef enum logic [3:0] {
		st_idle    = 4'b0001,
		st_hdr1    = 4'b0010,
		st_payload = 4'b0100,
		st_skip    = 4'b1000
	} state_e;

	state_e    state;
	tlp_hdr0_u hdr0;
	logic      accept;
	logic      take;
	logic      cur_cpl, cur_mem, cur_addr64;
	logic      lat_cpl, lat_mem, lat_addr64;

	// decode the beat as a first header beat
	assign hdr0       = rx.data;
	assign cur_cpl    = hdr0.cpl.typ == tlp_type_cpl_d;
	assign cur_mem    = hdr0.req.typ[4:1] == tlp_type_mem_prefix;
	assign cur_addr64 = hdr0.req.fmt[0];

	assign accept    = rx.valid && ready;
	assign take      = (bar_hit && en_bar) || (cur_cpl && en_cpl);
	assign tlp_start = accept && (state == st_idle) && take;

	always_comb begin
		case (state)
			st_idle:    emit = tlp_start;
			st_hdr1:    emit = accept;
			st_payload: emit = accept;
			default:    emit = 1'b0;
		endcase
	end

	always_comb begin
		case (state)
			st_idle: beat_kind = beat_hdr0;
			st_hdr1: beat_kind = beat_hdr1;
			default: beat_kind = beat_payload;
		endcase
	end

	// live decode on the first beat, latched flags after it
	assign hdr_is_cpl = (state == st_idle) ? cur_cpl : lat_cpl;
	assign hdr_is_mem = (state == st_idle) ? cur_mem : lat_mem;
	assign hdr_addr64 = (state == st_idle) ? cur_addr64 : lat_addr64;

	always_ff @(posedge clk) begin
		if (sys_rst) begin
			state      <= st_idle;
			ready      <= 1'b0;
			lat_cpl    <= 1'b0;
			lat_mem    <= 1'b0;
			lat_addr64 <= 1'b0;
		end else begin
			ready <= !almost_full;
			if (accept) begin
				case (state)
					st_idle: begin
						if (take) begin
							lat_cpl    <= cur_cpl;
							lat_mem    <= cur_mem;
							lat_addr64 <= cur_addr64;
							state      <= rx.last ? st_idle : st_hdr1;
						end else if (!rx.last) begin
							state <= st_skip;
						end
					end
					st_hdr1:
						state <= rx.last ? st_idle : st_payload;
					default:
						if (rx.last)
							state <= st_idle;
				endcase
			end
		end
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (sys_rst)
		$onehot(state));

endmodule

//--- rtl/tlp_tunnel_top.sv
`timescale 1ns/1ps

module tlp_tunnel_top #(
	parameter int fifo_depth_log2 = 5
) (
	input  logic                     clk,
	input  logic                     sys_rst,
	input  logic [63:0]              rx_tdata,
	input  logic [7:0]               rx_tkeep,
	input  logic                     rx_tlast,
	input  logic                     rx_tvalid,
	output logic                     rx_tready,
	input  logic [21:0]              rx_tuser,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [3:2]               wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	input  logic                     fifo_rd_en,
	output tunnel_pkg::tunnel_word_t fifo_dout,
	output logic                     fifo_empty
);
	import tunnel_pkg::*;

	rx_beat_if rx ();

	logic         bar_hit;
	logic         en_bar, en_cpl;
	logic         almost_full;
	logic         emit;
	beat_kind_e   beat_kind;
	logic         hdr_is_cpl, hdr_is_mem, hdr_addr64;
	logic         tlp_start;
	logic [47:12] paddr;
	tunnel_word_t wr_word;
	logic         wr_en;

	assign rx.data  = rx_tdata;
	assign rx.keep  = rx_tkeep;
	assign rx.last  = rx_tlast;
	assign rx.valid = rx_tvalid;

	// bar2 hit flag from the core's tuser
	assign bar_hit = rx_tuser[4];

	tlp_snoop_ctrl u_ctrl (
		.clk(clk), .sys_rst(sys_rst), .rx(rx), .bar_hit(bar_hit),
		.en_bar(en_bar), .en_cpl(en_cpl), .almost_full(almost_full),
		.ready(rx_tready), .emit(emit), .beat_kind(beat_kind),
		.hdr_is_cpl(hdr_is_cpl), .hdr_is_mem(hdr_is_mem),
		.hdr_addr64(hdr_addr64), .tlp_start(tlp_start)
	);

	tlp_hdr_rewrite u_rewrite (
		.clk(clk), .sys_rst(sys_rst), .rx(rx), .emit(emit), .beat_kind(beat_kind),
		.hdr_is_cpl(hdr_is_cpl), .hdr_is_mem(hdr_is_mem), .hdr_addr64(hdr_addr64),
		.paddr(paddr), .wr_word(wr_word), .wr_en(wr_en)
	);

	tunnel_regs u_regs (
		.clk(clk), .sys_rst(sys_rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .tlp_start(tlp_start), .en_bar(en_bar), .en_cpl(en_cpl),
		.paddr(paddr)
	);

	tunnel_fifo #(
		.fifo_depth_log2(fifo_depth_log2)
	) u_fifo (
		.clk(clk), .sys_rst(sys_rst), .wr_word(wr_word), .wr_en(wr_en),
		.rd_en(fifo_rd_en), .dout(fifo_dout), .empty(fifo_empty),
		.almost_full(almost_full)
	);

endmodule

//--- rtl/tunnel_fifo.sv
`timescale 1ns/1ps

module tunnel_fifo #(
	parameter int fifo_depth_log2 = 5
) (
	input  logic                     clk,
	input  logic                     sys_rst,
	input  tunnel_pkg::tunnel_word_t wr_word,
	input  logic                     wr_en,
	input  logic                     rd_en,
	output tunnel_pkg::tunnel_word_t dout,
	output logic                     empty,
	output logic                     almost_full
);
	import tunnel_pkg::*;

	localparam int depth = 1 << fifo_depth_log2;

	tunnel_word_t               mem [depth];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	logic [fifo_depth_log2:0]   count;
	logic                       full;
	logic                       do_rd;

	assign full  = count == depth;
	assign empty = count == 0;
	// fewer than 3 free entries
	assign almost_full = count > depth - 3;

	assign do_rd = rd_en && !empty;

	// show-ahead, head word always on dout
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// back-pressure upstream must keep writes away from a full array
	a_no_overflow: assert property (@(posedge clk) disable iff (sys_rst)
		wr_en |-> !full);

	// a pop always finds a word between the pointers
	a_no_underflow: assert property (@(posedge clk) disable iff (sys_rst)
		do_rd |-> (full || wr_ptr != rd_ptr));

endmodule

//--- rtl/tunnel_pkg.sv
package tunnel_pkg;

	// rx stream widths
	localparam int data_w = 64;
	localparam int keep_w = 8;

	// sideband byte at the top of every tunnel word
	typedef struct packed {
		logic [3:0] tag;
		logic       keep4;
		logic       keep0;
		logic       last;
		logic       valid;
	} tunnel_sb_t;

	localparam logic [3:0] sb_tag = 4'hA;

	typedef struct packed {
		tunnel_sb_t         sb;
		logic [data_w-1:0]  data;
	} tunnel_word_t;

	typedef enum logic [1:0] {
		beat_hdr0    = 2'd0,
		beat_hdr1    = 2'd1,
		beat_payload = 2'd2
	} beat_kind_e;

	// wishbone word addresses
	typedef enum logic [1:0] {
		reg_ctrl      = 2'd0,
		reg_paddr_lo  = 2'd1,
		reg_paddr_hi  = 2'd2,
		reg_fwd_count = 2'd3
	} reg_addr_e;

endpackage

//--- rtl/tunnel_regs.sv
`timescale 1ns/1ps

module tunnel_regs (
	input  logic         clk,
	input  logic         sys_rst,
	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  logic [3:2]   wb_adr,
	input  logic [31:0]  wb_dat_w,
	output logic [31:0]  wb_dat_r,
	output logic         wb_ack,
	input  logic         tlp_start,
	output logic         en_bar,
	output logic         en_cpl,
	output logic [47:12] paddr
);
	import tunnel_pkg::*;

	reg_addr_e   addr;
	logic        wb_req;
	logic [31:0] fwd_count;

	assign addr = reg_addr_e'(wb_adr);

	// new cycle only while no ack is out
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk) begin
		if (sys_rst) begin
			wb_ack    <= 1'b0;
			en_bar    <= 1'b1;
			en_cpl    <= 1'b1;
			paddr     <= '0;
			fwd_count <= '0;
		end else begin
			wb_ack <= wb_req;
			if (wb_req && wb_we) begin
				case (addr)
					reg_ctrl: begin
						en_bar <= wb_dat_w[0];
						en_cpl <= wb_dat_w[1];
					end
					reg_paddr_lo: paddr[31:12] <= wb_dat_w[31:12];
					reg_paddr_hi: paddr[47:32] <= wb_dat_w[15:0];
					default: ;
				endcase
			end
			// wraps at 32 bits
			if (tlp_start)
				fwd_count <= fwd_count + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_req) begin
			case (addr)
				reg_ctrl:     wb_dat_r <= {30'd0, en_cpl, en_bar};
				reg_paddr_lo: wb_dat_r <= {paddr[31:12], 12'h000};
				reg_paddr_hi: wb_dat_r <= {16'h0000, paddr[47:32]};
				default:      wb_dat_r <= fwd_count;
			endcase
		end
	end

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (sys_rst)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

//--- verification/tb_tlp_tunnel.sv
`timescale 1ns/1ps

module tb_tlp_tunnel;
	import tlp_pkg::*;
	import tunnel_pkg::*;

	localparam int depth_log2 = 5;

	logic         clk;
	logic         sys_rst;
	logic [63:0]  rx_tdata;
	logic [7:0]   rx_tkeep;
	logic         rx_tlast;
	logic         rx_tvalid;
	logic         rx_tready;
	logic [21:0]  rx_tuser;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [3:2]   wb_adr;
	logic [31:0]  wb_dat_w;
	logic [31:0]  wb_dat_r;
	logic         wb_ack;
	logic         fifo_rd_en;
	tunnel_word_t fifo_dout;
	logic         fifo_empty;

	// reference model state
	tunnel_word_t exp_q[$];
	logic [47:12] paddr_m;
	logic         en_bar_m;
	logic         en_cpl_m;
	int unsigned  fwd_m;
	int           rd_prob;
	logic         saw_stall;
	string        test_name;

	tlp_tunnel_top #(
		.fifo_depth_log2(depth_log2)
	) uut (
		.clk(clk), .sys_rst(sys_rst), .rx_tdata(rx_tdata), .rx_tkeep(rx_tkeep),
		.rx_tlast(rx_tlast), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
		.rx_tuser(rx_tuser), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.fifo_rd_en(fifo_rd_en), .fifo_dout(fifo_dout), .fifo_empty(fifo_empty)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input tunnel_word_t expected,
			input tunnel_word_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "tunnel word mismatch");
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "register mismatch");
		end
	endtask

	// one falling edge, then the random read side
	task automatic next_cycle();
		tunnel_word_t head;
		logic         rd;
		@(negedge clk);
		rd = ($urandom % 100) < rd_prob;
		if (rd && !fifo_empty) begin
			if (exp_q.size() == 0) begin
				stop_run($sformatf("FIFO gave a word the model does not expect: %h", fifo_dout));
			end else begin
				head = exp_q.pop_front();
				check_word(test_name, head, fifo_dout);
			end
		end
		fifo_rd_en = rd;
	endtask

	task automatic wb_access(input logic we, input reg_addr_e addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = addr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			next_cycle();
			waited++;
			if (waited > 20)
				stop_run("timeout: no Wishbone ack within 20 cycles");
		end while (!wb_ack);
		rdata = wb_dat_r;
		// hold the cycle through the edge that takes the ack
		next_cycle();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic set_window(input logic [47:12] win);
		logic [31:0] rd;
		// low bits of paddr_lo and high bits of paddr_hi are not stored
		wb_access(1'b1, reg_paddr_lo, {win[31:12], 12'hABC}, rd);
		wb_access(1'b1, reg_paddr_hi, {16'hFFFF, win[47:32]}, rd);
		paddr_m = win;
		wb_access(1'b0, reg_paddr_lo, 32'h0, rd);
		check_reg(test_name, {win[31:12], 12'h000}, rd);
		wb_access(1'b0, reg_paddr_hi, 32'h0, rd);
		check_reg(test_name, {16'h0000, win[47:32]}, rd);
	endtask

	task automatic set_ctrl(input logic [1:0] bits);
		logic [31:0] rd;
		wb_access(1'b1, reg_ctrl, {30'd0, bits}, rd);
		en_bar_m = bits[0];
		en_cpl_m = bits[1];
		wb_access(1'b0, reg_ctrl, 32'h0, rd);
		check_reg(test_name, {30'd0, bits}, rd);
	endtask

	// expected data of beat idx after the header rules
	function automatic logic [63:0] expect_data(input int idx, input logic [63:0] d,
			input logic cpl, input logic mem, input logic a64);
		logic [63:0] r;
		r = d;
		if (idx == 0) begin
			if (!cpl)
				r[63:60] = ~d[63:60];
		end else if (idx == 1) begin
			if (mem && !a64)
				r[31:20] = paddr_m[31:20];
			else if (mem)
				r = {paddr_m[31:20], d[19:0], 16'h0000, paddr_m[47:32]};
			else if (cpl)
				r[31:28] = ~d[31:28];
		end
		return r;
	endfunction

	task automatic send_beat(input logic [63:0] d, input logic [7:0] keep, input logic last,
			input logic [21:0] user, input logic fwd, input tunnel_word_t w);
		int waited;
		// occasional idle cycle between beats
		if (($urandom % 4) == 0)
			next_cycle();
		rx_tdata  = d;
		rx_tkeep  = keep;
		rx_tlast  = last;
		rx_tuser  = user;
		rx_tvalid = 1'b1;
		waited    = 0;
		while (!rx_tready) begin
			saw_stall = 1'b1;
			waited++;
			if (waited > 2000)
				stop_run("timeout: rx_tready stayed low for 2000 cycles");
			next_cycle();
		end
		if (fwd)
			exp_q.push_back(w);
		next_cycle();
		rx_tvalid = 1'b0;
	endtask

	// kind: 0 mrd32, 1 mwr32, 2 mrd64, 3 mwr64, 4 cpl, other msg
	task automatic send_tlp(input int kind);
		req_hdr0_t    h;
		logic [63:0]  d;
		logic [31:0]  rnd;
		logic [21:0]  user;
		logic [7:0]   keep;
		logic         bar, cpl, mem, a64, fwd, last;
		int           npay;
		tunnel_word_t w;
		h    = {$urandom, $urandom};
		npay = 0;
		case (kind)
			0: begin
				h.fmt = 2'b00;
				h.typ = 5'b00000;
			end
			1: begin
				h.fmt = 2'b10;
				h.typ = 5'b00000;
				npay  = 1 + $urandom % 4;
			end
			2: begin
				h.fmt = 2'b01;
				h.typ = 5'b00000;
			end
			3: begin
				h.fmt = 2'b11;
				h.typ = 5'b00000;
				npay  = 1 + $urandom % 4;
			end
			4: begin
				h.fmt = 2'b10;
				h.typ = 5'b01010;
				npay  = 1 + $urandom % 6;
			end
			default: begin
				h.fmt      = 2'b01;
				h.typ[4:3] = 2'b10;
			end
		endcase
		if (kind == 4)
			bar = 1'b0;
		else if (kind >= 5)
			bar = $urandom % 2;
		else
			bar = ($urandom % 4) != 0;
		rnd     = $urandom;
		user    = rnd[21:0];
		user[4] = bar;
		cpl = h.typ == 5'b01010;
		mem = h.typ[4:1] == 4'b0000;
		a64 = h.fmt[0];
		fwd = (bar && en_bar_m) || (cpl && en_cpl_m);
		if (fwd)
			fwd_m++;
		for (int i = 0; i < 2 + npay; i++) begin
			if (i == 0)
				d = h;
			else
				d = {$urandom, $urandom};
			last   = i == 1 + npay;
			keep   = (last && ($urandom % 2)) ? 8'h0F : 8'hFF;
			w.sb   = {4'hA, keep[4], keep[0], last, 1'b1};
			w.data = expect_data(i, d, cpl, mem, a64);
			send_beat(d, keep, last, user, fwd, w);
		end
	endtask

	task automatic drain_fifo();
		int waited;
		rd_prob = 100;
		waited  = 0;
		while (exp_q.size() != 0 || !fifo_empty) begin
			waited++;
			if (waited > 500)
				stop_run("timeout: FIFO did not drain, words are missing");
			next_cycle();
		end
		repeat (4) next_cycle();
		if (!fifo_empty)
			stop_run("FIFO holds words after the model queue emptied");
	endtask

	initial begin
		logic [31:0] rd;
		logic [63:0] rnd64;
		void'($urandom(57789));
		sys_rst    = 1'b1;
		rx_tdata   = '0;
		rx_tkeep   = '0;
		rx_tlast   = 1'b0;
		rx_tvalid  = 1'b0;
		rx_tuser   = '0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		fifo_rd_en = 1'b0;
		rd_prob    = 70;
		saw_stall  = 1'b0;
		fwd_m      = 0;
		en_bar_m   = 1'b1;
		en_cpl_m   = 1'b1;
		paddr_m    = '0;
		test_name  = "reset_values";
		repeat (10) @(negedge clk);
		sys_rst = 1'b0;

		wb_access(1'b0, reg_ctrl, 32'h0, rd);
		check_reg(test_name, 32'h0000_0003, rd);
		wb_access(1'b0, reg_fwd_count, 32'h0, rd);
		check_reg(test_name, 32'h0, rd);

		test_name = "reg_write_read";
		rnd64 = {$urandom, $urandom};
		set_window(rnd64[47:12]);

		test_name = "header_rewrite";
		for (int n = 0; n < 60; n++) begin
			if (n == 30) begin
				rnd64 = {$urandom, $urandom};
				set_window(rnd64[47:12]);
			end
			send_tlp($urandom % 6);
		end

		// completions only, then bar hits only, then nothing
		test_name = "filtering";
		set_ctrl(2'b10);
		repeat (25) send_tlp($urandom % 6);
		set_ctrl(2'b01);
		repeat (25) send_tlp($urandom % 6);
		set_ctrl(2'b00);
		repeat (10) send_tlp($urandom % 6);
		set_ctrl(2'b11);

		// slow reader so the FIFO fills
		test_name = "back_pressure";
		drain_fifo();
		saw_stall = 1'b0;
		rd_prob   = 4;
		repeat (30) send_tlp(($urandom % 2) ? 4 : 3);
		if (!saw_stall)
			stop_run("rx_tready never dropped while the reader was slow");
		drain_fifo();

		test_name = "fwd_count";
		wb_access(1'b0, reg_fwd_count, 32'h0, rd);
		check_reg(test_name, fwd_m, rd);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- verilog.f
rtl/tlp_pkg.sv
rtl/tunnel_pkg.sv
rtl/rx_beat_if.sv
rtl/tlp_snoop_ctrl.sv
rtl/tlp_hdr_rewrite.sv
rtl/tunnel_regs.sv
rtl/tunnel_fifo.sv
rtl/tlp_tunnel_top.sv
verification/tb_tlp_tunnel.sv
